// ==== tb.f ====
common/sram_pkg.sv
common/mem_port_if.sv
common/sram_cmd_if.sv
sram_ctrl/port_arbiter.sv
sram_ctrl/sram_bus_ctrl.sv
source/sram_two_port_top.sv
dv/sram_bank_model.sv
dv/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import sram_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int NUM_WORDS    = 16;
    localparam int NUM_PAIRS    = 8;
    localparam int NUM_ACCESS   = 4 * NUM_WORDS + 4 * NUM_PAIRS + 2 * NUM_PAIRS;
    localparam int CYCLE_LIMIT  = 4 * NUM_ACCESS + RESET_CYCLES + 50;

    logic              clk_n = 1'b0;
    logic              rst_n;
    logic [ADDR_W-1:0] address1, address2, ram_address;
    logic [DATA_W-1:0] wrdata1, wrdata2, rddata1, rddata2;
    logic [BE_W-1:0]   dataenable1, dataenable2, dataenable_n;
    logic              rd1, wr1, rd2, wr2, stall1, stall2;
    logic [DATA_W-1:0] ram_data_o, ram_data_i_base, ram_data_i_ext;
    logic              ram_wr_n, ram_rd_n, ram_io_t, ram_base_ce_n, ram_ext_ce_n;

    logic [31:0]       lfsr = 32'hb29f;
    int                cyc = 0;
    logic [BE_W-1:0]   be_expect = '0;  // Lane enables of the write in flight.
    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0] addr_list [NUM_WORDS];

    always #20 clk_n = ~clk_n;

    sram_two_port_top #(.BANK_SEL_BIT(DEFAULT_BANK_SEL)) u_dut (.*);

    sram_bank_model u_base (
        .address (ram_address), .data_in (ram_data_o), .data_out (ram_data_i_base),
        .be_n (dataenable_n), .wr_n (ram_wr_n), .rd_n (ram_rd_n), .ce_n (ram_base_ce_n)
    );

    sram_bank_model u_ext (
        .address (ram_address), .data_in (ram_data_o), .data_out (ram_data_i_ext),
        .be_n (dataenable_n), .wr_n (ram_wr_n), .rd_n (ram_rd_n), .ce_n (ram_ext_ce_n)
    );

    task automatic value_fail(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, sig, got, exp);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic rule_fail(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [DATA_W-1:0] shadow_read(input logic [ADDR_W-1:0] a);
        return shadow.exists(a) ? shadow[a] : '0;
    endfunction

    function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old,
                                                input logic [DATA_W-1:0] data,
                                                input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic port_stall(input int port);
        return (port == 2) ? stall2 : stall1;
    endfunction

    task automatic drive_port(input int port, input logic rd, input logic wr,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [BE_W-1:0] be);
        if (port == 2) begin
            address2    <= addr;
            wrdata2     <= data;
            dataenable2 <= be;
            rd2         <= rd;
            wr2         <= wr;
        end else begin
            address1    <= addr;
            wrdata1     <= data;
            dataenable1 <= be;
            rd1         <= rd;
            wr1         <= wr;
        end
    endtask

    // Called just after a rising edge. Returns one idle cycle after completion.
    task automatic access(input int port, input logic is_wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be,
                          output logic [DATA_W-1:0] rdata);
        if (is_wr) begin
            be_expect = be;
        end
        drive_port(port, !is_wr, is_wr, addr, data, be);
        @(posedge clk_n);
        while (!port_stall(port)) @(posedge clk_n);
        while (port_stall(port)) @(posedge clk_n);
        rdata = (port == 2) ? rddata2 : rddata1;
        drive_port(port, 1'b0, 1'b0, addr, data, be);
        @(posedge clk_n);
    endtask

    task automatic write_word(input int port, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] unused;
        access(port, 1'b1, addr, data, be, unused);
        shadow[addr] = merge(shadow_read(addr), data, be);
    endtask

    task automatic read_check(input int port, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp;
        exp = shadow_read(addr);
        access(port, 1'b0, addr, '0, '0, got);
        assert (got === exp) else value_fail((port == 2) ? "rddata2" : "rddata1", got, exp);
    endtask

    // Both ports request on the same edge. Port 2 must finish two cycles ahead.
    task automatic dual_read(input logic [ADDR_W-1:0] a1, input logic [ADDR_W-1:0] a2);
        int                fall1;
        int                fall2;
        logic              done1;
        logic              done2;
        logic [DATA_W-1:0] got1;
        logic [DATA_W-1:0] got2;
        done1 = 1'b0;
        done2 = 1'b0;
        drive_port(1, 1'b1, 1'b0, a1, '0, '0);
        drive_port(2, 1'b1, 1'b0, a2, '0, '0);
        @(posedge clk_n);
        while (!(done1 && done2)) begin
            @(posedge clk_n);
            if (!done2 && !stall2) begin
                done2 = 1'b1;
                fall2 = cyc;
                got2  = rddata2;
                drive_port(2, 1'b0, 1'b0, a2, '0, '0);
            end
            if (!done1 && !stall1) begin
                done1 = 1'b1;
                fall1 = cyc;
                got1  = rddata1;
                drive_port(1, 1'b0, 1'b0, a1, '0, '0);
            end
        end
        @(posedge clk_n);
        assert (fall1 == fall2 + 2) else value_fail("stall1 fall cycle", fall1, fall2 + 2);
        assert (got2 === shadow_read(a2)) else value_fail("rddata2", got2, shadow_read(a2));
        assert (got1 === shadow_read(a1)) else value_fail("rddata1", got1, shadow_read(a1));
    endtask

    assert property (@(negedge clk_n) (cyc > 1 && $past(!rst_n)) |->
        (ram_wr_n && ram_rd_n && ram_io_t && ram_base_ce_n && ram_ext_ce_n && !stall1 && !stall2))
        else rule_fail("SRAM pins or stalls not idle around reset");

    assert property (@(negedge clk_n) disable iff (!rst_n) !(!ram_wr_n && !ram_rd_n))
        else rule_fail("ram_wr_n and ram_rd_n low together");

    assert property (@(negedge clk_n) disable iff (!rst_n) !ram_wr_n |=> ram_wr_n)
        else rule_fail("ram_wr_n low for more than one cycle");

    assert property (@(negedge clk_n) disable iff (!rst_n) !ram_rd_n |=> ram_rd_n)
        else rule_fail("ram_rd_n low for more than one cycle");

    assert property (@(negedge clk_n) disable iff (!rst_n)
        u_dut.cmd_if.issue |=> (ram_wr_n ^ ram_rd_n))
        else rule_fail("access issued without exactly one strobe");

    assert property (@(negedge clk_n) disable iff (!rst_n) ram_io_t == ram_wr_n)
        else value_fail("ram_io_t", 32'(ram_io_t), 32'(ram_wr_n));

    assert property (@(negedge clk_n) disable iff (!rst_n) !ram_wr_n |-> dataenable_n == ~be_expect)
        else value_fail("dataenable_n", 32'(dataenable_n), 32'(~be_expect));

    assert property (@(negedge clk_n) disable iff (!rst_n) (!ram_wr_n || !ram_rd_n) |->
        (ram_address[DEFAULT_BANK_SEL] ? (!ram_ext_ce_n && ram_base_ce_n)
                                       : (!ram_base_ce_n && ram_ext_ce_n)))
        else rule_fail("wrong chip enable for the access address");

    assert property (@(negedge clk_n) disable iff (!rst_n) (ram_wr_n && ram_rd_n) |->
        (ram_base_ce_n && ram_ext_ce_n))
        else rule_fail("chip enable low without a strobe");

    always @(negedge clk_n) begin
        cyc <= cyc + 1;
        if (cyc > CYCLE_LIMIT) begin
            $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    initial begin
        logic [ADDR_W-1:0] a;
        rst_n       = 1'b0;
        address1    = '0;
        wrdata1     = '0;
        dataenable1 = '0;
        rd1         = 1'b0;
        wr1         = 1'b0;
        address2    = '0;
        wrdata2     = '0;
        dataenable2 = '0;
        rd2         = 1'b0;
        wr2         = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_n);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk_n);

        for (int i = 0; i < NUM_WORDS; i++) begin
            a = rand_bits(12);
            a[DEFAULT_BANK_SEL] = 1'(rand_bits(1));
            addr_list[i] = a;
            write_word(int'(rand_bits(1)) + 1, a, rand_bits(32), '1);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            read_check(int'(rand_bits(1)) + 1, addr_list[i]);
        end

        for (int i = 0; i < NUM_WORDS; i++) begin
            write_word(int'(rand_bits(1)) + 1, addr_list[i], rand_bits(32),
                       BE_W'(rand_bits(BE_W)));
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            read_check(int'(rand_bits(1)) + 1, addr_list[i]);
        end

        for (int i = 0; i < NUM_PAIRS; i++) begin
            a = rand_bits(12);
            write_word(2, a, rand_bits(32), '1);
            write_word(1, a | (32'd1 << DEFAULT_BANK_SEL), rand_bits(32), '1);
            read_check(1, a);
            read_check(2, a | (32'd1 << DEFAULT_BANK_SEL));
        end

        for (int i = 0; i < NUM_PAIRS; i++) begin
            dual_read(addr_list[i], addr_list[NUM_WORDS - 1 - i]);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== dv/sram_bank_model.sv ====
`timescale 1ns/1ps

// Behavioral asynchronous SRAM bank. Locations never written read as zero.
module sram_bank_model import sram_pkg::*; (
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out,
    input  logic [BE_W-1:0]   be_n,
    input  logic              wr_n,
    input  logic              rd_n,
    input  logic              ce_n
);

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];

    // The write lands a little after the strobe falls, once address and data have settled.
    always @(negedge wr_n) begin
        #1;
        if (!ce_n && !wr_n) begin
            if (!mem.exists(address)) begin
                mem[address] = '0;
            end
            for (int i = 0; i < BE_W; i++) begin
                if (!be_n[i]) begin
                    mem[address][i*8 +: 8] = data_in[i*8 +: 8];
                end
            end
        end
    end

    always @(ce_n or rd_n or address) begin
        if (!ce_n && !rd_n && mem.exists(address)) begin
            data_out = mem[address];
        end else begin
            data_out = '0;  // The bus floats low when the bank is not read.
        end
    end

endmodule

// ==== source/sram_two_port_top.sv ====
`timescale 1ns/1ps

module sram_two_port_top import sram_pkg::*; #(
    parameter int BANK_SEL_BIT = DEFAULT_BANK_SEL
) (
    input  logic              clk_n,
    input  logic              rst_n,
    // Port 1 is the instruction fetch port.
    input  logic [ADDR_W-1:0] address1,
    input  logic [DATA_W-1:0] wrdata1,
    input  logic [BE_W-1:0]   dataenable1,
    input  logic              rd1,
    input  logic              wr1,
    output logic [DATA_W-1:0] rddata1,
    output logic              stall1,
    // Port 2 is the data port and has priority.
    input  logic [ADDR_W-1:0] address2,
    input  logic [DATA_W-1:0] wrdata2,
    input  logic [BE_W-1:0]   dataenable2,
    input  logic              rd2,
    input  logic              wr2,
    output logic [DATA_W-1:0] rddata2,
    output logic              stall2,
    // SRAM pins.
    output logic [ADDR_W-1:0] ram_address,
    output logic [DATA_W-1:0] ram_data_o,
    input  logic [DATA_W-1:0] ram_data_i_base,
    input  logic [DATA_W-1:0] ram_data_i_ext,
    output logic              ram_wr_n,
    output logic              ram_rd_n,
    output logic              ram_io_t,
    output logic              ram_base_ce_n,
    output logic              ram_ext_ce_n,
    output logic [BE_W-1:0]   dataenable_n
);

    mem_port_if port1_if ();
    mem_port_if port2_if ();
    sram_cmd_if cmd_if ();

    assign port1_if.address    = address1;
    assign port1_if.wrdata     = wrdata1;
    assign port1_if.dataenable = dataenable1;
    assign port1_if.rd         = rd1;
    assign port1_if.wr         = wr1;
    assign rddata1             = port1_if.rddata;
    assign stall1              = port1_if.stall;

    assign port2_if.address    = address2;
    assign port2_if.wrdata     = wrdata2;
    assign port2_if.dataenable = dataenable2;
    assign port2_if.rd         = rd2;
    assign port2_if.wr         = wr2;
    assign rddata2             = port2_if.rddata;
    assign stall2              = port2_if.stall;

    port_arbiter u_arbiter (
        .clk_n (clk_n),
        .rst_n (rst_n),
        .port1 (port1_if.arbiter),
        .port2 (port2_if.arbiter),
        .cmd   (cmd_if.arbiter)
    );

    sram_bus_ctrl #(
        .BANK_SEL_BIT (BANK_SEL_BIT)
    ) u_bus (
        .clk_n           (clk_n),
        .rst_n           (rst_n),
        .cmd             (cmd_if.bus),
        .ram_address     (ram_address),
        .ram_data_o      (ram_data_o),
        .ram_data_i_base (ram_data_i_base),
        .ram_data_i_ext  (ram_data_i_ext),
        .ram_wr_n        (ram_wr_n),
        .ram_rd_n        (ram_rd_n),
        .ram_io_t        (ram_io_t),
        .ram_base_ce_n   (ram_base_ce_n),
        .ram_ext_ce_n    (ram_ext_ce_n),
        .dataenable_n    (dataenable_n)
    );

endmodule

// ==== sram_ctrl/sram_bus_ctrl.sv ====
`timescale 1ns/1ps

module sram_bus_ctrl import sram_pkg::*; #(
    parameter int BANK_SEL_BIT = DEFAULT_BANK_SEL
) (
    input  logic              clk_n,
    input  logic              rst_n,
    sram_cmd_if.bus           cmd,
    output logic [ADDR_W-1:0] ram_address,
    output logic [DATA_W-1:0] ram_data_o,
    input  logic [DATA_W-1:0] ram_data_i_base,
    input  logic [DATA_W-1:0] ram_data_i_ext,
    output logic              ram_wr_n,
    output logic              ram_rd_n,
    output logic              ram_io_t,
    output logic              ram_base_ce_n,
    output logic              ram_ext_ce_n,
    output logic [BE_W-1:0]   dataenable_n
);

    logic [DATA_W-1:0] data_i_reg_base;
    logic [DATA_W-1:0] data_i_reg_ext;
    logic              rd_from_ext;
    logic              hit_ext;
    logic              issue_wr;
    logic              issue_rd;

    assign hit_ext  = cmd.cmd.addr[BANK_SEL_BIT];
    assign issue_wr = cmd.issue & cmd.cmd.wr;
    assign issue_rd = cmd.issue & ~cmd.cmd.wr;

    // Strobes and chip enables. Each pulses low for the one cycle after issue.
    always_ff @(negedge clk_n) begin
        if (!rst_n) begin
            ram_wr_n      <= 1'b1;
            ram_rd_n      <= 1'b1;
            ram_io_t      <= 1'b1;
            ram_base_ce_n <= 1'b1;
            ram_ext_ce_n  <= 1'b1;
        end else begin
            ram_wr_n      <= ~issue_wr;
            ram_rd_n      <= ~issue_rd;
            ram_io_t      <= ~issue_wr;  // Drive the data pins only while writing.
            ram_base_ce_n <= ~(cmd.issue & ~hit_ext);
            ram_ext_ce_n  <= ~(cmd.issue & hit_ext);
        end
    end

    // Address, write data and lane enables hold from one issue to the next.
    always_ff @(negedge clk_n) begin
        if (cmd.issue) begin
            ram_address  <= cmd.cmd.addr;
            ram_data_o   <= cmd.cmd.wrdata;
            dataenable_n <= ~cmd.cmd.be;
        end
    end

    // On capture, both banks are still driven from the access just issued.
    // The chip enables still show which of the two was selected.
    always_ff @(negedge clk_n) begin
        if (cmd.capture) begin
            data_i_reg_base <= ram_data_i_base;
            data_i_reg_ext  <= ram_data_i_ext;
            rd_from_ext     <= ~ram_ext_ce_n;
        end
    end

    assign cmd.rddata = rd_from_ext ? data_i_reg_ext : data_i_reg_base;

endmodule

// ==== sram_ctrl/port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter import sram_pkg::*; (
    input logic         clk_n,
    input logic         rst_n,
    mem_port_if.arbiter port1,
    mem_port_if.arbiter port2,
    sram_cmd_if.arbiter cmd
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t    state;
    logic      served2;  // Set while port 2 owns the access in flight.
    logic      req1;
    logic      req2;
    sram_cmd_t sel_cmd;

    assign req1 = port1.rd | port1.wr;
    assign req2 = port2.rd | port2.wr;

    // The bus controller registers the pins on the same edge at which the
    // arbiter leaves idle, so issue is decoded from the current state.
    assign cmd.issue   = (state == ST_IDLE) && (req1 || req2);
    assign cmd.capture = (state == ST_BUSY);

    always_comb begin
        if (req2) begin  // Port 2 always wins.
            sel_cmd.addr   = port2.address;
            sel_cmd.wrdata = port2.wrdata;
            sel_cmd.be     = port2.dataenable;
            sel_cmd.wr     = port2.wr;
        end else begin
            sel_cmd.addr   = port1.address;
            sel_cmd.wrdata = port1.wrdata;
            sel_cmd.be     = port1.dataenable;
            sel_cmd.wr     = port1.wr;
        end
    end

    assign cmd.cmd = sel_cmd;

    // Both masters see the same captured word. Only the one whose stall
    // has just fallen takes it.
    assign port1.rddata = cmd.rddata;
    assign port2.rddata = cmd.rddata;

    always_ff @(negedge clk_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            served2     <= 1'b0;
            port1.stall <= 1'b0;
            port2.stall <= 1'b0;
        end else begin
            // A pending request keeps its port stalled until its capture edge.
            port1.stall <= req1;
            port2.stall <= req2;
            case (state)
                ST_IDLE: begin
                    if (req1 || req2) begin
                        state   <= ST_BUSY;
                        served2 <= req2;
                    end
                end
                ST_BUSY: begin
                    state <= ST_IDLE;
                    if (served2) begin
                        port2.stall <= 1'b0;
                    end else begin
                        port1.stall <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== common/sram_cmd_if.sv ====
`timescale 1ns/1ps

// Arbiter to bus controller path. Capture always follows issue by one edge.
interface sram_cmd_if import sram_pkg::*; ();

    logic              issue;
    logic              capture;
    sram_cmd_t         cmd;
    logic [DATA_W-1:0] rddata;

    modport arbiter (
        output issue,
        output capture,
        output cmd,
        input  rddata
    );

    modport bus (
        input  issue,
        input  capture,
        input  cmd,
        output rddata
    );

endinterface

// ==== common/mem_port_if.sv ====
`timescale 1ns/1ps

// One bus master port with the rd/wr/stall handshake.
interface mem_port_if import sram_pkg::*; ();

    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] wrdata;
    logic [BE_W-1:0]   dataenable;
    logic              rd;
    logic              wr;
    logic              stall;
    logic [DATA_W-1:0] rddata;

    // The master holds its request until stall falls.
    modport master (
        output address,
        output wrdata,
        output dataenable,
        output rd,
        output wr,
        input  stall,
        input  rddata
    );

    modport arbiter (
        input  address,
        input  wrdata,
        input  dataenable,
        input  rd,
        input  wr,
        output stall,
        output rddata
    );

endinterface

// ==== common/sram_pkg.sv ====
package sram_pkg;

    // Widths shared by the port side and the SRAM side.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;  // One enable per byte lane.

    // Address bit that selects the ext bank. When it is clear, the access goes to the base bank.
    localparam int DEFAULT_BANK_SEL = 22;

    // The request that won arbitration, as handed to the bus controller.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wrdata;
        logic [BE_W-1:0]   be;      // Active high with one bit per byte lane.
        logic              wr;      // Clear for a read.
    } sram_cmd_t;

endpackage
